//--- build.f
+incdir+tb
src/exec_pkg.sv
src/alu.sv
src/issue_queue.sv
src/exec_unit.sv
tb/tb_exec_unit.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_exec_unit -f build.f

out=$(./obj_dir/Vtb_exec_unit 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

//--- src/alu.sv
`default_nettype none
`timescale 1ns/1ns

module alu
    import exec_pkg::*;
(
    input  logic    clk_in,
    input  logic    rst,
    input  logic    flush,
    // one-cycle strobe, accepted every cycle
    input  logic    issue_valid,
    input  issue_t  issue,
    // one-cycle pulse per instruction
    output logic    result_valid,
    output result_t result
);

    word_t alu_out;
    logic [4:0] shamt;
    // signed view of operands for compare and arithmetic shift
    logic signed [WORD_W-1:0] op1_s;
    logic signed [WORD_W-1:0] op2_s;

    // only low five bits count for shifts
    assign shamt = issue.op2[4:0];
    assign op1_s = issue.op1;
    assign op2_s = issue.op2;

    always_comb begin
        case (issue.func)
            Add:  alu_out = issue.op1 + issue.op2;
            Sub:  alu_out = issue.op1 - issue.op2;
            And:  alu_out = issue.op1 & issue.op2;
            Or:   alu_out = issue.op1 | issue.op2;
            Xor:  alu_out = issue.op1 ^ issue.op2;
            // signed less than
            Slt:  alu_out = word_t'(op1_s < op2_s);
            // unsigned less than
            Sltu: alu_out = word_t'(issue.op1 < issue.op2);
            Sll:  alu_out = issue.op1 << shamt;
            // logical, zero fill
            Srl:  alu_out = issue.op1 >> shamt;
            // arithmetic, sign fill
            Sra:  alu_out = word_t'(op1_s >>> shamt);
            default: alu_out = '0;
        endcase
    end

    // strobe register, flush drops whatever is in flight
    always_ff @(posedge clk_in) begin
        if (rst || flush) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= issue_valid;
        end
    end

    // payload travels with the strobe
    always_ff @(posedge clk_in) begin
        if (issue_valid) begin
            result <= '{rob_ix: issue.rob_ix, data: alu_out};
        end
    end

    // queue is empty after flush, so nothing can come out two cycles later
    assert property (@(posedge clk_in) disable iff (rst)
        flush |-> ##2 !result_valid);

    // every issue returns next cycle with its own index
    assert property (@(posedge clk_in) disable iff (rst)
        (issue_valid && !flush) |=> (result_valid && result.rob_ix == $past(issue.rob_ix)));

endmodule

`default_nettype wire

//--- src/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // reorder buffer index width, also the wakeup tag width
    localparam int ROB_IX_W = 3;
    // data path width
    localparam int WORD_W = 32;
    // issue queue size
    localparam int IQ_DEPTH = 4;
    localparam int IQ_SLOT_W = 2;
    // alu function code width
    localparam int ALU_FUNC_W = 4;

    typedef logic [ROB_IX_W-1:0] rob_ix_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [IQ_SLOT_W-1:0] iq_slot_t;

    // ten alu functions, codes above Sra are unused
    typedef enum logic [ALU_FUNC_W-1:0] {
        Add,
        Sub,
        And,
        Or,
        Xor,
        Slt,
        Sltu,
        Sll,
        Srl,
        Sra
    } alu_func_e;

    // one source operand, tag is only meaningful while not ready
    typedef struct packed {
        logic    ready;
        rob_ix_t tag;
        word_t   value;
    } src_operand_t;

    // instruction as it arrives from dispatch
    typedef struct packed {
        alu_func_e    func;
        rob_ix_t      rob_ix;
        src_operand_t src1;
        src_operand_t src2;
    } dispatch_t;

    // instruction leaving the queue with both operands resolved
    typedef struct packed {
        alu_func_e func;
        rob_ix_t   rob_ix;
        word_t     op1;
        word_t     op2;
    } issue_t;

    // result bus payload, also used for wakeup
    typedef struct packed {
        rob_ix_t rob_ix;
        word_t   data;
    } result_t;

endpackage

`default_nettype wire

//--- src/exec_unit.sv
`default_nettype none
`timescale 1ns/1ns

module exec_unit
    import exec_pkg::*;
(
    input  logic      clk_in,
    input  logic      rst,
    input  logic      flush,
    // dispatch in
    input  logic      dispatch_valid,
    input  dispatch_t dispatch,
    output logic      dispatch_ready,
    // result bus out, no back-pressure
    output logic      result_valid,
    output result_t   result
);

    // queue to alu
    logic   issue_valid;
    issue_t issue;

    // operand wait, wakeup and select
    issue_queue u_issue_queue (
        .clk_in         (clk_in),
        .rst            (rst),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        // result bus looped back as wakeup
        .wake_valid     (result_valid),
        .wake           (result),
        .issue_valid    (issue_valid),
        .issue          (issue)
    );

    // single cycle alu with registered result
    alu u_alu (
        .clk_in       (clk_in),
        .rst          (rst),
        .flush        (flush),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

//--- src/issue_queue.sv
`default_nettype none
`timescale 1ns/1ns

module issue_queue
    import exec_pkg::*;
(
    input  logic      clk_in,
    input  logic      rst,
    input  logic      flush,
    // dispatch side, strobe qualified by ready level
    input  logic      dispatch_valid,
    input  dispatch_t dispatch,
    output logic      dispatch_ready,
    // result bus fed back for wakeup
    input  logic      wake_valid,
    input  result_t   wake,
    // towards the alu
    output logic      issue_valid,
    output issue_t    issue
);

    // slot storage
    logic [IQ_DEPTH-1:0] slot_valid;
    dispatch_t slot_q [IQ_DEPTH];
    dispatch_t slot_d [IQ_DEPTH];

    // incoming instruction after the dispatch bypass
    dispatch_t dispatch_woken;
    logic accept;

    // search results
    logic [IQ_DEPTH-1:0] slot_ready;
    logic free_found;
    iq_slot_t free_ix;
    logic issue_found;
    iq_slot_t issue_ix;

    // set when two live slots carry one index
    logic dup_rob_ix;

    // tag match against the result bus
    function automatic src_operand_t wake_src(
        input src_operand_t src,
        input logic         hit_valid,
        input result_t      hit
    );
        src_operand_t res;
        res = src;
        if (hit_valid && !src.ready && src.tag == hit.rob_ix) begin
            res.ready = 1'b1;
            res.value = hit.data;
        end
        return res;
    endfunction

    // a result on the bus this cycle must not be missed by a new entry
    always_comb begin
        dispatch_woken = dispatch;
        dispatch_woken.src1 = wake_src(dispatch.src1, wake_valid, wake);
        dispatch_woken.src2 = wake_src(dispatch.src2, wake_valid, wake);
    end

    // free slot and ready slot searches, lowest number wins both
    always_comb begin
        free_found = 1'b0;
        free_ix = '0;
        issue_found = 1'b0;
        issue_ix = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            slot_ready[i] = slot_valid[i] && slot_q[i].src1.ready && slot_q[i].src2.ready;
            if (!slot_valid[i] && !free_found) begin
                free_found = 1'b1;
                free_ix = iq_slot_t'(i);
            end
            if (slot_ready[i] && !issue_found) begin
                issue_found = 1'b1;
                issue_ix = iq_slot_t'(i);
            end
        end
    end

    // ready while any slot is free
    assign dispatch_ready = free_found;
    assign accept = dispatch_valid && dispatch_ready;

    // issue straight from the stored slot
    assign issue_valid = issue_found;
    assign issue = '{
        func:   slot_q[issue_ix].func,
        rob_ix: slot_q[issue_ix].rob_ix,
        op1:    slot_q[issue_ix].src1.value,
        op2:    slot_q[issue_ix].src2.value
    };

    // next slot contents, wakeup on every slot or new entry in the free one
    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (accept && free_ix == iq_slot_t'(i)) begin
                slot_d[i] = dispatch_woken;
            end else begin
                slot_d[i] = slot_q[i];
                slot_d[i].src1 = wake_src(slot_q[i].src1, wake_valid, wake);
                slot_d[i].src2 = wake_src(slot_q[i].src2, wake_valid, wake);
            end
        end
    end

    // valid bits, issue frees a slot at the issue edge
    always_ff @(posedge clk_in) begin
        if (rst || flush) begin
            slot_valid <= '0;
        end else begin
            for (int i = 0; i < IQ_DEPTH; i++) begin
                if (issue_found && issue_ix == iq_slot_t'(i)) begin
                    slot_valid[i] <= 1'b0;
                end else if (accept && free_ix == iq_slot_t'(i)) begin
                    slot_valid[i] <= 1'b1;
                end
            end
        end
    end

    // payload, meaningless while the valid bit is low
    always_ff @(posedge clk_in) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            slot_q[i] <= slot_d[i];
        end
    end

    // pairwise index compare across live slots
    always_comb begin
        dup_rob_ix = 1'b0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            for (int j = i + 1; j < IQ_DEPTH; j++) begin
                if (slot_valid[i] && slot_valid[j] &&
                    slot_q[i].rob_ix == slot_q[j].rob_ix) begin
                    dup_rob_ix = 1'b1;
                end
            end
        end
    end

    // sender must hold off while the queue is full
    assert property (@(posedge clk_in) disable iff (rst)
        dispatch_valid |-> dispatch_ready);

    // operands came in by dispatch or an earlier wakeup
    assert property (@(posedge clk_in) disable iff (rst)
        issue_valid |-> (slot_q[issue_ix].src1.ready && slot_q[issue_ix].src2.ready));

    // rob never hands out an index twice while in flight
    assert property (@(posedge clk_in) disable iff (rst)
        !dup_rob_ix);

endmodule

`default_nettype wire

//--- tb/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

localparam int ROB_N = 2 ** ROB_IX_W;

// one entry per rob index
// waiting for its result
logic  in_flight [ROB_N];
// value the result must carry
word_t exp_value [ROB_N];
// result already came back
logic  seen [ROB_N];

// reference alu, shifts take the low five bits of b
function automatic word_t alu_ref(input alu_func_e func, input word_t a, input word_t b);
    case (func)
        Add: return a + b;
        Sub: return a - b;
        And: return a & b;
        Or: return a | b;
        Xor: return a ^ b;
        // different signs decide on their own, else plain compare
        Slt: return (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
        Sltu: return word_t'(a < b);
        Sll: return a << b[4:0];
        Srl: return a >> b[4:0];
        // zero fill shift, then copies of the sign bit into the vacated top bits
        Sra: return (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
        default: return '0;
    endcase
endfunction

task automatic clear_table();
    for (int i = 0; i < ROB_N; i++) begin
        in_flight[i] = 1'b0;
        seen[i] = 1'b0;
    end
endtask

task automatic record_expected(input rob_ix_t ix, input word_t value);
    in_flight[ix] = 1'b1;
    seen[ix] = 1'b0;
    exp_value[ix] = value;
endtask

// result off the bus, compared and its index freed
task automatic check_result(input rob_ix_t ix, input word_t data);
    if (in_flight[ix]) begin
        check_value(data, exp_value[ix], $sformatf("result of rob_ix %0d", ix));
        in_flight[ix] = 1'b0;
        seen[ix] = 1'b1;
    end else begin
        $display("Error at %0t: result for rob_ix %0d, which is not in flight%s", $time, ix,
                 seen[ix] ? ", second result" : "");
        other_errors++;
    end
endtask

function automatic int count_pending();
    int n;
    n = 0;
    for (int i = 0; i < ROB_N; i++) begin
        if (in_flight[i]) begin
            n++;
        end
    end
    return n;
endfunction

// whatever is still in flight never returned
task automatic report_lost();
    for (int i = 0; i < ROB_N; i++) begin
        if (in_flight[i]) begin
            $display("Error: the result for rob_ix %0d was never returned", i);
            other_errors++;
        end
    end
    clear_table();
endtask

`endif

//--- tb/tb_exec_unit.sv
`default_nettype none
`timescale 1ns/1ns

module tb_exec_unit
    import exec_pkg::*;
();

    localparam int NUM_INSTR = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 20;
    // longest chain through the queue, with margin
    localparam int DRAIN_LIMIT = 64;

    logic      clk_in;
    logic      rst;
    logic      flush;
    logic      dispatch_valid;
    dispatch_t dispatch;
    logic      dispatch_ready;
    logic      result_valid;
    result_t   result;

    logic [31:0] lcg_state = 32'h3330da49;
    int mismatches = 0;
    int other_errors = 0;
    int sent = 0;
    int cycle_count = 0;

    exec_unit dut_i (.*);

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input word_t got, input word_t want, input string what);
        if (got !== want) begin
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, want);
            mismatches++;
        end
    endtask

    `include "exec_model.svh"

    // random start so indices come out in no fixed order
    task automatic pick_index(input logic want_busy, output logic found, output rob_ix_t ix);
        rob_ix_t start;
        rob_ix_t cand;
        start = rob_ix_t'(lcg_next() >> 16);
        found = 1'b0;
        ix = '0;
        for (int k = 0; k < ROB_N; k++) begin
            cand = rob_ix_t'(start + k);
            if (!found && in_flight[cand] == want_busy) begin
                found = 1'b1;
                ix = cand;
            end
        end
    endtask

    // shift amounts up to 63, small negatives, full range words
    function automatic word_t rand_operand();
        logic [31:0] r;
        r = lcg_next();
        case (r[17:16])
            2'd0: return word_t'(r[31:26]);
            2'd1: return -word_t'(r[31:28]);
            default: return lcg_next();
        endcase
    endfunction

    task automatic send_instr(input dispatch_t d, input word_t value);
        dispatch = d;
        dispatch_valid = 1'b1;
        record_expected(d.rob_ix, value);
        sent++;
    endtask

    // src1 may wait on a tag, src2 always ready
    task automatic send_fixed(input rob_ix_t ix, input alu_func_e func, input logic wait1,
                              input rob_ix_t tag, input word_t v1, input word_t v2);
        dispatch_t d;
        d.func = func;
        d.rob_ix = ix;
        d.src1 = '{ready: !wait1, tag: tag, value: v1};
        d.src2 = '{ready: 1'b1, tag: '0, value: v2};
        send_instr(d, alu_ref(func, v1, v2));
    endtask

    // one falling edge: maybe dispatch, then look at the result bus
    task automatic cycle_step(input logic allow_new);
        dispatch_t d;
        src_operand_t src [2];
        word_t v [2];
        rob_ix_t ix;
        rob_ix_t tag;
        logic found;
        logic dep_found;
        logic [31:0] r;
        @(negedge clk_in);
        dispatch_valid = 1'b0;
        r = lcg_next();
        if (allow_new && dispatch_ready && r[19:18] != 2'b00) begin
            pick_index(1'b0, found, ix);
            if (found) begin
                for (int s = 0; s < 2; s++) begin
                    v[s] = rand_operand();
                    src[s] = '{ready: 1'b1, tag: '0, value: v[s]};
                    r = lcg_next();
                    // producer on the bus right now still counts, the bypass catches it
                    pick_index(1'b1, dep_found, tag);
                    if (r[17] && dep_found) begin
                        src[s].ready = 1'b0;
                        src[s].tag = tag;
                        v[s] = exp_value[tag];
                    end
                end
                d.func = alu_func_e'(4'((r >> 20) % 10));
                d.rob_ix = ix;
                d.src1 = src[0];
                d.src2 = src[1];
                send_instr(d, alu_ref(d.func, v[0], v[1]));
            end
        end
        if (result_valid) begin
            check_result(result.rob_ix, result.data);
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (count_pending() != 0 && n < DRAIN_LIMIT) begin
            cycle_step(1'b0);
            n++;
        end
        report_lost();
    endtask

    always @(posedge clk_in) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Summary: %0d mismatches, %0d other errors", mismatches, other_errors + 1);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        flush = 1'b0;
        dispatch_valid = 1'b0;
        dispatch = '0;
        clear_table();
        repeat (3) @(posedge clk_in);
        @(negedge clk_in);
        rst = 1'b0;
        // idle outputs straight out of reset
        check_value(word_t'(result_valid), 32'd0, "result_valid after reset");
        check_value(word_t'(dispatch_ready), 32'd1, "dispatch_ready after reset");

        // mixed independent and dependent traffic
        while (sent < NUM_INSTR) begin
            cycle_step(1'b1);
        end
        drain();

        // three slots wait on each other in a loop, the fourth issues into the alu
        cycle_step(1'b0);
        send_fixed(3'd0, Add, 1'b1, 3'd2, 32'd5, 32'd7);
        cycle_step(1'b0);
        send_fixed(3'd1, Xor, 1'b1, 3'd0, 32'd9, 32'hff);
        cycle_step(1'b0);
        send_fixed(3'd2, Sub, 1'b1, 3'd1, 32'd3, 32'd1);
        cycle_step(1'b0);
        send_fixed(3'd3, Sra, 1'b0, 3'd0, 32'h8000_0000, 32'd36);
        cycle_step(1'b0);
        check_value(word_t'(dispatch_ready), 32'd0, "dispatch_ready with four slots taken");
        flush = 1'b1;
        cycle_step(1'b0);
        flush = 1'b0;
        // flushed indices dropped, a later result for one of them is an error
        clear_table();
        check_value(word_t'(dispatch_ready), 32'd1, "dispatch_ready after flush");
        check_value(word_t'(result_valid), 32'd0, "result_valid after flush");
        repeat (8) cycle_step(1'b0);
        // unsigned compare against a negative word
        send_fixed(3'd5, Sltu, 1'b0, 3'd0, 32'd3, 32'hffff_fffe);
        drain();

        $display("Summary: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
